/* source/otp_part_pkg.sv */
/*
 * Widths, codes and the OTP word union shared by the read-only partition.
 * OTP is halfword addressed; a block and the digest are 64 bits wide.
 */
package otp_part_pkg;

  // One OTP block, also the digest width
  parameter int unsigned BlockWidth    = 64;
  // Bus read data
  parameter int unsigned BusDataWidth  = 32;

  // Byte and halfword addresses into the OTP macro
  parameter int unsigned ByteAddrWidth = 11;
  parameter int unsigned OtpAddrWidth  = 10;
  parameter int unsigned OtpAddrShift  = 1;

  // Bus word address, byte address without the two low bits
  parameter int unsigned BusAddrWidth  = 9;

  // Number of halfwords minus one
  parameter int unsigned OtpSizeWidth  = 2;

  typedef enum logic {
    ReadRaw = 1'b0,
    Read    = 1'b1
  } otp_cmd_e;

  typedef enum logic [2:0] {
    NoError             = 3'd0,
    MacroError          = 3'd1,
    MacroEccCorrError   = 3'd2,
    MacroEccUncorrError = 3'd3,
    AccessError         = 3'd4,
    FsmStateError       = 3'd5
  } otp_err_e;

  // Read word, seen as a digest block or as a bus word in the low half
  typedef union packed {
    logic [BlockWidth-1:0] block;
    struct packed {
      logic [BlockWidth-BusDataWidth-1:0] unused;
      logic [BusDataWidth-1:0]            data;
    } word;
  } otp_block_u;

endpackage

/* source/otp_part_init.sv */
/*
 * Reads the partition digest once per reset and holds it.
 * A failed read or a fatal condition stops init until the next reset.
 */
`timescale 1ns/1ps

module otp_part_init (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                init_req_i,
  input  logic                                fatal_i,
  output logic                                init_req_o,
  input  logic                                init_gnt_i,
  input  logic                                init_rvalid_i,
  input  logic                                init_ok_i,
  input  otp_part_pkg::otp_block_u            otp_rdata_i,
  output logic                                init_done_o,
  output logic [otp_part_pkg::BlockWidth-1:0] digest_o
);

  // State codes
  localparam logic [1:0] ResetSt = 2'd0;
  localparam logic [1:0] ReqSt   = 2'd1;
  localparam logic [1:0] WaitSt  = 2'd2;
  localparam logic [1:0] DoneSt  = 2'd3;

  logic [1:0] state_d, state_q;
  logic       digest_en;

  always_comb begin
    state_d    = state_q;
    init_req_o = 1'b0;
    digest_en  = 1'b0;
    case (state_q)
      ResetSt: begin
        if (init_req_i) begin
          state_d = ReqSt;
        end
      end
      // Hold the request until the macro takes it
      ReqSt: begin
        init_req_o = 1'b1;
        if (init_gnt_i) begin
          state_d = WaitSt;
        end
      end
      // A bad response drops back, the port has gone fatal by then
      WaitSt: begin
        if (init_rvalid_i) begin
          if (init_ok_i) begin
            digest_en = 1'b1;
            state_d   = DoneSt;
          end else begin
            state_d = ResetSt;
          end
        end
      end
      default: begin
        state_d = DoneSt;
      end
    endcase
    // Terminal condition parks the sequencer for good
    if (fatal_i) begin
      state_d = ResetSt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
    end else begin
      state_q <= state_d;
    end
  end

  // Digest holds the whole block
  always_ff @(posedge clk_i) begin
    if (digest_en) begin
      digest_o <= otp_rdata_i.block;
    end
  end

  assign init_done_o = (state_q == DoneSt);

endmodule

/* source/otp_part_read.sv */
/*
 * Serves one 32-bit bus read at a time from the partition window.
 * Out-of-window or locked reads return a bus error without an OTP access.
 */
`timescale 1ns/1ps

module otp_part_read #(
  parameter int unsigned PartOffset = 64,
  parameter int unsigned PartSize   = 128
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    init_done_i,
  input  logic                                    fatal_i,
  input  logic                                    read_lock_i,
  input  logic                                    bus_req_i,
  input  logic [otp_part_pkg::BusAddrWidth-1:0]   bus_addr_i,
  output logic                                    bus_gnt_o,
  output logic                                    bus_rvalid_o,
  output logic [1:0]                              bus_rerror_o,
  output logic [otp_part_pkg::BusDataWidth-1:0]   bus_rdata_o,
  output logic                                    rd_req_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0]   rd_addr_o,
  input  logic                                    rd_gnt_i,
  input  logic                                    rd_rvalid_i,
  input  logic                                    rd_ok_i,
  input  otp_part_pkg::otp_block_u                otp_rdata_i,
  output logic                                    access_err_o
);

  import otp_part_pkg::*;

  // Window bounds, one bit wider so the end cannot wrap
  localparam logic [ByteAddrWidth:0] PartStart = (ByteAddrWidth+1)'(PartOffset);
  localparam logic [ByteAddrWidth:0] PartEnd   = (ByteAddrWidth+1)'(PartOffset + PartSize);

  localparam logic [1:0] IdleSt = 2'd0;
  localparam logic [1:0] ReadSt = 2'd1;
  localparam logic [1:0] WaitSt = 2'd2;

  logic [1:0]               state_d, state_q;
  logic [BusAddrWidth-1:0]  addr_q;
  logic [ByteAddrWidth-1:0] byte_addr;
  logic                     in_range;

  assign byte_addr = {addr_q, 2'b00};
  assign in_range  = ({1'b0, byte_addr} >= PartStart) && ({1'b0, byte_addr} < PartEnd);
  assign rd_addr_o = byte_addr[ByteAddrWidth-1:OtpAddrShift];

  ////////////////////////////////////////////////////////////////////////////
  // Read FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    bus_gnt_o    = 1'b0;
    bus_rvalid_o = 1'b0;
    bus_rerror_o = 2'b00;
    rd_req_o     = 1'b0;
    access_err_o = 1'b0;
    case (state_q)
      // Terminal state still grants, so the requester never hangs
      IdleSt: begin
        if (bus_req_i && (init_done_i || fatal_i)) begin
          bus_gnt_o = 1'b1;
          state_d   = ReadSt;
        end
      end
      ReadSt: begin
        if (fatal_i || !in_range || read_lock_i) begin
          bus_rvalid_o = 1'b1;
          bus_rerror_o = 2'b11;
          // Soft error only, the port latches AccessError
          access_err_o = !fatal_i;
          state_d      = IdleSt;
        end else begin
          rd_req_o = 1'b1;
          if (rd_gnt_i) begin
            state_d = WaitSt;
          end
        end
      end
      // Answer in the same cycle as the macro response
      WaitSt: begin
        if (rd_rvalid_i) begin
          bus_rvalid_o = 1'b1;
          bus_rerror_o = rd_ok_i ? 2'b00 : 2'b11;
          state_d      = IdleSt;
        end
      end
      default: begin
        state_d = IdleSt;
      end
    endcase
  end

  // No data leaves on an error
  assign bus_rdata_o = (bus_rvalid_o && bus_rerror_o == 2'b00) ? otp_rdata_i.word.data : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IdleSt;
    end else begin
      state_q <= state_d;
    end
  end

  // Address is taken with the grant
  always_ff @(posedge clk_i) begin
    if (bus_gnt_o) begin
      addr_q <= bus_addr_i;
    end
  end

endmodule

/* source/otp_part_port.sv */
/*
 * Shares the single OTP macro port between init and read engines.
 * Only one OTP access may be outstanding; init has priority when both ask.
 * Holds the partition error code and the terminal error latch.
 */
`timescale 1ns/1ps

module otp_part_port #(
  parameter int unsigned PartOffset = 64,
  parameter int unsigned PartSize   = 128,
  parameter bit          Integrity  = 1'b1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  escalate_i,
  input  logic                                  init_req_i,
  output logic                                  init_gnt_o,
  output logic                                  init_rvalid_o,
  output logic                                  init_ok_o,
  input  logic                                  rd_req_i,
  input  logic [otp_part_pkg::OtpAddrWidth-1:0] rd_addr_i,
  output logic                                  rd_gnt_o,
  output logic                                  rd_rvalid_o,
  output logic                                  rd_ok_o,
  input  logic                                  bus_grant_i,
  input  logic                                  access_err_i,
  output logic                                  otp_req_o,
  output otp_part_pkg::otp_cmd_e                otp_cmd_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0] otp_size_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr_o,
  input  logic                                  otp_gnt_i,
  input  logic                                  otp_rvalid_i,
  input  otp_part_pkg::otp_err_e                otp_err_i,
  output otp_part_pkg::otp_err_e                error_o,
  output logic                                  fatal_o,
  output logic                                  fsm_err_o
);

  import otp_part_pkg::*;

  // Digest sits in the last block of the partition
  localparam int unsigned DigestByte = PartOffset + PartSize - BlockWidth / 8;
  localparam logic [OtpAddrWidth-1:0] DigestAddr = OtpAddrWidth'(DigestByte >> OtpAddrShift);
  // Sizes count 16-bit halfwords minus one
  localparam logic [OtpSizeWidth-1:0] DigestSize = OtpSizeWidth'(BlockWidth / 16 - 1);
  localparam logic [OtpSizeWidth-1:0] WordSize   = OtpSizeWidth'(BusDataWidth / 16 - 1);

  logic     owner_q;
  logic     fatal_d, fatal_q;
  logic     resp_ok;
  otp_err_e otp_err;
  otp_err_e error_d, error_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // Nothing reaches the macro once terminal
  assign otp_req_o  = !fatal_q && (init_req_i || rd_req_i);
  assign otp_cmd_o  = Integrity ? Read : ReadRaw;
  assign otp_addr_o = init_req_i ? DigestAddr : rd_addr_i;
  assign otp_size_o = init_req_i ? DigestSize : WordSize;
  assign init_gnt_o = otp_req_o && otp_gnt_i && init_req_i;
  assign rd_gnt_o   = otp_req_o && otp_gnt_i && !init_req_i;

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  // Without integrity the ECC codes carry no meaning
  always_comb begin
    otp_err = otp_err_i;
    if (!Integrity && otp_err_i inside {MacroEccCorrError, MacroEccUncorrError}) begin
      otp_err = NoError;
    end
  end

  // Corrected data is still good
  assign resp_ok       = !fatal_q && (otp_err inside {NoError, MacroEccCorrError});
  assign init_rvalid_o = otp_rvalid_i && owner_q;
  assign init_ok_o     = resp_ok;
  assign rd_rvalid_o   = otp_rvalid_i && !owner_q;
  assign rd_ok_o       = resp_ok;

  // Error register and terminal latch
  always_comb begin
    error_d   = error_q;
    fatal_d   = fatal_q;
    fsm_err_o = 1'b0;
    if (!fatal_q) begin
      if (bus_grant_i) begin
        error_d = NoError;
      end
      if (access_err_i) begin
        error_d = AccessError;
      end
      if (otp_rvalid_i && otp_err != NoError) begin
        error_d = otp_err;
        fatal_d = (otp_err != MacroEccCorrError);
      end
      // Single pulse, the latch masks it afterwards
      if (escalate_i) begin
        fsm_err_o = 1'b1;
        fatal_d   = 1'b1;
        if (error_d == NoError) begin
          error_d = FsmStateError;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= 1'b0;
      fatal_q <= 1'b0;
      error_q <= NoError;
    end else begin
      fatal_q <= fatal_d;
      error_q <= error_d;
      // Response goes back to whoever got the grant
      if (otp_req_o && otp_gnt_i) begin
        owner_q <= init_req_i;
      end
    end
  end

  assign error_o = error_q;
  assign fatal_o = fatal_q;

endmodule

/* source/otp_part_lock.sv */
/*
 * Registered read and write locks, both locked out of reset.
 * An uninitialized partition is always locked.
 */
`timescale 1ns/1ps

module otp_part_lock #(
  parameter bit ReadLockByDigest  = 1'b0,
  parameter bit WriteLockByDigest = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                init_done_i,
  input  logic [otp_part_pkg::BlockWidth-1:0] digest_i,
  input  logic                                read_lock_i,
  input  logic                                write_lock_i,
  output logic                                read_lock_o,
  output logic                                write_lock_o
);

  logic digest_set;

  // A written digest means the partition is sealed
  assign digest_set = (digest_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_lock_o  <= 1'b1;
      write_lock_o <= 1'b1;
    end else begin
      read_lock_o  <= !init_done_i || read_lock_i || (ReadLockByDigest && digest_set);
      write_lock_o <= !init_done_i || write_lock_i || (WriteLockByDigest && digest_set);
    end
  end

endmodule

/* source/otp_part_top.sv */
/*
 * Read-only OTP partition with its digest.
 * Offset and size must be block aligned; the last block holds the digest.
 */
`timescale 1ns/1ps

module otp_part_top #(
  parameter int unsigned PartOffset        = 64,
  parameter int unsigned PartSize          = 128,
  parameter bit          Integrity         = 1'b1,
  parameter bit          ReadLockByDigest  = 1'b0,
  parameter bit          WriteLockByDigest = 1'b1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Init and escalation
  input  logic                                  init_req_i,
  output logic                                  init_done_o,
  input  logic                                  escalate_i,
  output otp_part_pkg::otp_err_e                error_o,
  output logic                                  fsm_err_o,
  // Locks and digest
  input  logic                                  read_lock_i,
  input  logic                                  write_lock_i,
  output logic                                  read_lock_o,
  output logic                                  write_lock_o,
  output logic [otp_part_pkg::BlockWidth-1:0]   digest_o,
  // Bus read port
  input  logic                                  bus_req_i,
  output logic                                  bus_gnt_o,
  input  logic [otp_part_pkg::BusAddrWidth-1:0] bus_addr_i,
  output logic [1:0]                            bus_rerror_o,
  output logic                                  bus_rvalid_o,
  output logic [otp_part_pkg::BusDataWidth-1:0] bus_rdata_o,
  // OTP macro port
  output logic                                  otp_req_o,
  output otp_part_pkg::otp_cmd_e                otp_cmd_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0] otp_size_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr_o,
  input  logic                                  otp_gnt_i,
  input  logic                                  otp_rvalid_i,
  input  otp_part_pkg::otp_block_u              otp_rdata_i,
  input  otp_part_pkg::otp_err_e                otp_err_i
);

  import otp_part_pkg::*;

  // Init sequencer to port
  logic init_req, init_gnt, init_rvalid, init_ok;
  // Read engine to port
  logic                    rd_req, rd_gnt, rd_rvalid, rd_ok;
  logic [OtpAddrWidth-1:0] rd_addr;
  logic                    fatal, access_err;

  otp_part_init otp_part_init_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_req_i    (init_req_i),
    .fatal_i       (fatal),
    .init_req_o    (init_req),
    .init_gnt_i    (init_gnt),
    .init_rvalid_i (init_rvalid),
    .init_ok_i     (init_ok),
    .otp_rdata_i   (otp_rdata_i),
    .init_done_o   (init_done_o),
    .digest_o      (digest_o)
  );

  otp_part_read #(
    .PartOffset (PartOffset),
    .PartSize   (PartSize)
  ) otp_part_read_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .init_done_i  (init_done_o),
    .fatal_i      (fatal),
    .read_lock_i  (read_lock_o),
    .bus_req_i    (bus_req_i),
    .bus_addr_i   (bus_addr_i),
    .bus_gnt_o    (bus_gnt_o),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rerror_o (bus_rerror_o),
    .bus_rdata_o  (bus_rdata_o),
    .rd_req_o     (rd_req),
    .rd_addr_o    (rd_addr),
    .rd_gnt_i     (rd_gnt),
    .rd_rvalid_i  (rd_rvalid),
    .rd_ok_i      (rd_ok),
    .otp_rdata_i  (otp_rdata_i),
    .access_err_o (access_err)
  );

  otp_part_port #(
    .PartOffset (PartOffset),
    .PartSize   (PartSize),
    .Integrity  (Integrity)
  ) otp_part_port_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .escalate_i    (escalate_i),
    .init_req_i    (init_req),
    .init_gnt_o    (init_gnt),
    .init_rvalid_o (init_rvalid),
    .init_ok_o     (init_ok),
    .rd_req_i      (rd_req),
    .rd_addr_i     (rd_addr),
    .rd_gnt_o      (rd_gnt),
    .rd_rvalid_o   (rd_rvalid),
    .rd_ok_o       (rd_ok),
    .bus_grant_i   (bus_gnt_o),
    .access_err_i  (access_err),
    .otp_req_o     (otp_req_o),
    .otp_cmd_o     (otp_cmd_o),
    .otp_size_o    (otp_size_o),
    .otp_addr_o    (otp_addr_o),
    .otp_gnt_i     (otp_gnt_i),
    .otp_rvalid_i  (otp_rvalid_i),
    .otp_err_i     (otp_err_i),
    .error_o       (error_o),
    .fatal_o       (fatal),
    .fsm_err_o     (fsm_err_o)
  );

  otp_part_lock #(
    .ReadLockByDigest  (ReadLockByDigest),
    .WriteLockByDigest (WriteLockByDigest)
  ) otp_part_lock_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .init_done_i  (init_done_o),
    .digest_i     (digest_o),
    .read_lock_i  (read_lock_i),
    .write_lock_i (write_lock_i),
    .read_lock_o  (read_lock_o),
    .write_lock_o (write_lock_o)
  );

endmodule

/* bench/otp_macro_model.sv */
/*
 * Behavioral OTP macro: one access at a time, grant and response delays of 0..3 cycles.
 * Read word holds the halfword address in the low half and its inverse in the high half.
 * err_i is taken when the response leaves; outputs change on the falling edge.
 */
`timescale 1ns/1ps

module otp_macro_model (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  logic [otp_part_pkg::OtpAddrWidth-1:0] addr_i,
  input  otp_part_pkg::otp_err_e                err_i,
  output logic                                  gnt_o,
  output logic                                  rvalid_o,
  output otp_part_pkg::otp_block_u              rdata_o,
  output otp_part_pkg::otp_err_e                err_o
);

  import otp_part_pkg::*;

  // 8-bit Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
  localparam logic [7:0] LfsrSeed = 8'd71;
  localparam logic [7:0] LfsrTaps = 8'hB8;

  logic [7:0]              lfsr_q;
  logic                    busy_q;
  logic [1:0]              gnt_wait_q;
  logic [1:0]              resp_wait_q;
  logic [OtpAddrWidth-1:0] addr_q;

  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
  endfunction

  // One LFSR step per delay bit
  task automatic draw_delay(output logic [1:0] delay);
    for (int i = 0; i < 2; i++) begin
      delay[i] = lfsr_q[0];
      lfsr_q   = lfsr_next(lfsr_q);
    end
  endtask

  always @(negedge clk_i or negedge rst_ni) begin : macro_seq
    logic [1:0] delay;
    if (!rst_ni) begin
      lfsr_q = LfsrSeed;
      gnt_o       <= 1'b0;
      rvalid_o    <= 1'b0;
      rdata_o     <= '0;
      err_o       <= NoError;
      busy_q      <= 1'b0;
      gnt_wait_q  <= 2'd0;
      resp_wait_q <= 2'd0;
      addr_q      <= '0;
    end else begin
      rvalid_o <= 1'b0;
      err_o    <= NoError;
      if (gnt_o) begin
        // Grant was taken on the rising edge just passed
        gnt_o  <= 1'b0;
        busy_q <= 1'b1;
        draw_delay(delay);
        resp_wait_q <= delay;
      end else if (busy_q) begin
        if (resp_wait_q == 2'd0) begin
          rvalid_o      <= 1'b1;
          rdata_o.block <= {~(32'(addr_q)), 32'(addr_q)};
          err_o         <= err_i;
          busy_q        <= 1'b0;
          draw_delay(delay);
          gnt_wait_q <= delay;
        end else begin
          resp_wait_q <= resp_wait_q - 2'd1;
        end
      end else if (req_i && !rvalid_o) begin
        // Address is stable while the request waits
        if (gnt_wait_q == 2'd0) begin
          gnt_o  <= 1'b1;
          addr_q <= addr_i;
        end else begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
      end
    end
  end

endmodule

/* bench/otp_part_tb.sv */
/*
 * Testbench for the read-only OTP partition against a behavioral OTP macro.
 * Stimulus moves on the falling edge; assertions sample on the rising edge.
 * Stops at the first failing check.
 */
`timescale 1ns/1ps

module otp_part_tb;

  import otp_part_pkg::*;

  localparam int unsigned PartOffset     = 64;
  localparam int unsigned PartSize       = 128;
  localparam int unsigned NumTests       = 6;
  localparam int unsigned WatchdogCycles = NumTests * 200;
  // Halfword address of the digest block
  localparam logic [OtpAddrWidth-1:0] DigestAddr =
    OtpAddrWidth'((PartOffset + PartSize - 8) / 2);

  logic                    clk_i;
  logic                    rst_ni;
  logic                    init_req_i, init_done_o;
  logic                    escalate_i, fsm_err_o;
  otp_err_e                error_o;
  logic                    read_lock_i, write_lock_i, read_lock_o, write_lock_o;
  logic [BlockWidth-1:0]   digest_o;
  logic                    bus_req_i, bus_gnt_o, bus_rvalid_o;
  logic [BusAddrWidth-1:0] bus_addr_i;
  logic [1:0]              bus_rerror_o;
  logic [BusDataWidth-1:0] bus_rdata_o;
  logic                    otp_req_o, otp_gnt_i, otp_rvalid_i;
  otp_cmd_e                otp_cmd_o;
  logic [OtpSizeWidth-1:0] otp_size_o;
  logic [OtpAddrWidth-1:0] otp_addr_o;
  otp_block_u              otp_rdata_i;
  otp_err_e                otp_err_i;

  // Expectations for the access in flight
  string                   test_name;
  logic [1:0]              exp_rerror;
  logic [BusDataWidth-1:0] exp_rdata;
  logic                    exp_refused;
  logic                    exp_fatal;
  otp_err_e                exp_err_after;
  otp_err_e                inject_err;
  logic [BlockWidth-1:0]   exp_digest;
  // Handshakes as seen on the last rising edge
  logic                    gnt_seen, rvalid_seen;

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    gnt_seen    <= bus_req_i && bus_gnt_o;
    rvalid_seen <= bus_rvalid_o;
  end

  otp_part_top #(
    .PartOffset        (PartOffset),
    .PartSize          (PartSize),
    .Integrity         (1'b1),
    .ReadLockByDigest  (1'b0),
    .WriteLockByDigest (1'b1)
  ) otp_part_top_inst (
    .clk_i, .rst_ni, .init_req_i, .init_done_o, .escalate_i, .error_o, .fsm_err_o,
    .read_lock_i, .write_lock_i, .read_lock_o, .write_lock_o, .digest_o,
    .bus_req_i, .bus_gnt_o, .bus_addr_i, .bus_rerror_o, .bus_rvalid_o, .bus_rdata_o,
    .otp_req_o, .otp_cmd_o, .otp_size_o, .otp_addr_o, .otp_gnt_i, .otp_rvalid_i,
    .otp_rdata_i, .otp_err_i
  );

  otp_macro_model otp_macro_model_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (otp_req_o),
    .addr_i   (otp_addr_o),
    .err_i    (inject_err),
    .gnt_o    (otp_gnt_i),
    .rvalid_o (otp_rvalid_i),
    .rdata_o  (otp_rdata_i),
    .err_o    (otp_err_i)
  );

  // Macro word: address low, inverse high
  function automatic logic [BlockWidth-1:0] expected_word(input logic [OtpAddrWidth-1:0] addr);
    logic [31:0] low;
    low = 32'(addr);
    return {~low, low};
  endfunction

  // Bus word address to its 32-bit data half
  function automatic logic [BusDataWidth-1:0] word_data(input logic [BusAddrWidth-1:0] addr);
    logic [BlockWidth-1:0] word;
    word = expected_word({addr, 1'b0});
    return word[BusDataWidth-1:0];
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [63:0] exp_v, input logic [63:0] act_v);
    $display("ERR %s %s: expected 0x%0h, actual 0x%0h", name, what, exp_v, act_v);
    $display("Regression failed");
    $fatal(1, "Stopped at the first failing check");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Locked and idle until init is done
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !init_done_o && !exp_fatal |-> read_lock_o && write_lock_o)
    else report_mismatch(test_name, "locks", 2'b11, $sampled({read_lock_o, write_lock_o}));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i && !init_done_o && !exp_fatal |-> !bus_gnt_o)
    else report_mismatch(test_name, "early gnt", 0, $sampled(bus_gnt_o));
  // Idle engine grants in the same cycle, terminal state too
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_i && (init_done_o || exp_fatal) |-> bus_gnt_o)
    else report_mismatch(test_name, "gnt", 1, $sampled(bus_gnt_o));

  // Digest request follows init one cycle later
  assert property (@(posedge clk_i) disable iff (!rst_ni) init_req_i |=> otp_req_o)
    else report_mismatch(test_name, "otp_req", 1, $sampled(otp_req_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    init_req_i |=> otp_addr_o == DigestAddr)
    else report_mismatch(test_name, "otp_addr", DigestAddr, $sampled(otp_addr_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    init_req_i |=> otp_size_o == 2'd3 && otp_cmd_o == Read)
    else report_mismatch(test_name, "size/cmd", {2'd3, 1'b1},
                         $sampled({otp_size_o, otp_cmd_o}));
  // Bus reads fetch two halfwords
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    otp_req_o && init_done_o |-> otp_size_o == 2'd1 && otp_cmd_o == Read)
    else report_mismatch(test_name, "read size/cmd", {2'd1, 1'b1},
                         $sampled({otp_size_o, otp_cmd_o}));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(init_done_o) |-> digest_o == exp_digest)
    else report_mismatch(test_name, "digest", exp_digest, $sampled(digest_o));
  // Nonzero digest keeps the write lock
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(init_done_o) |=> write_lock_o && !read_lock_o)
    else report_mismatch(test_name, "locks", 2'b01, $sampled({read_lock_o, write_lock_o}));

  // Bus response contents
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rvalid_o |-> bus_rerror_o == exp_rerror)
    else report_mismatch(test_name, "rerror", exp_rerror, $sampled(bus_rerror_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rvalid_o |-> bus_rdata_o == exp_rdata)
    else report_mismatch(test_name, "rdata", exp_rdata, $sampled(bus_rdata_o));
  // Refused reads answer one cycle after the grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_gnt_o && exp_refused |=> bus_rvalid_o)
    else report_mismatch(test_name, "refused rvalid", 1, $sampled(bus_rvalid_o));
  // OTP reads answer together with the macro
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rvalid_o && !exp_refused |-> otp_rvalid_i)
    else report_mismatch(test_name, "otp_rvalid", 1, $sampled(otp_rvalid_i));

  // Error register
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_gnt_o && !exp_fatal |=> error_o == NoError)
    else report_mismatch(test_name, "error cleared", NoError, $sampled(error_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rvalid_o |=> error_o == exp_err_after)
    else report_mismatch(test_name, "error", exp_err_after, $sampled(error_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) exp_fatal |-> !otp_req_o)
    else report_mismatch(test_name, "otp_req terminal", 0, $sampled(otp_req_o));

  // Escalation pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) escalate_i && !exp_fatal |-> fsm_err_o)
    else report_mismatch(test_name, "fsm_err", 1, $sampled(fsm_err_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) fsm_err_o |=> !fsm_err_o)
    else report_mismatch(test_name, "fsm_err pulse", 0, $sampled(fsm_err_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni) fsm_err_o |=> error_o == FsmStateError)
    else report_mismatch(test_name, "escalation error", FsmStateError, $sampled(error_o));

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni    = 1'b0;
    exp_fatal = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic run_init();
    assert (init_done_o == 1'b0) else report_mismatch(test_name, "init_done", 0, init_done_o);
    @(negedge clk_i);
    init_req_i = 1'b1;
    @(negedge clk_i);
    init_req_i = 1'b0;
    while (!init_done_o) @(negedge clk_i);
    // Let the locks settle
    repeat (2) @(negedge clk_i);
  endtask

  task automatic bus_read(input logic [BusAddrWidth-1:0] addr, input logic [1:0] rerror,
                          input logic [BusDataWidth-1:0] rdata, input logic refused,
                          input otp_err_e err_after);
    @(negedge clk_i);
    exp_rerror    = rerror;
    exp_rdata     = rdata;
    exp_refused   = refused;
    exp_err_after = err_after;
    bus_req_i     = 1'b1;
    bus_addr_i    = addr;
    @(negedge clk_i);
    while (!gnt_seen) @(negedge clk_i);
    bus_req_i = 1'b0;
    while (!rvalid_seen) @(negedge clk_i);
    // One more edge for the checks that follow the response
    @(negedge clk_i);
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    init_req_i    = 1'b0;
    escalate_i    = 1'b0;
    read_lock_i   = 1'b0;
    write_lock_i  = 1'b0;
    bus_req_i     = 1'b0;
    bus_addr_i    = '0;
    inject_err    = NoError;
    exp_rerror    = 2'b00;
    exp_rdata     = '0;
    exp_refused   = 1'b0;
    exp_fatal     = 1'b0;
    exp_err_after = NoError;
    exp_digest    = expected_word(DigestAddr);
    test_name     = "reset";
    apply_reset();

    // Request before init must not be granted
    @(negedge clk_i);
    bus_req_i  = 1'b1;
    bus_addr_i = 9'd16;
    repeat (3) @(negedge clk_i);
    bus_req_i = 1'b0;
    test_name = "init";
    run_init();

    test_name = "good_read";
    bus_read(9'd16, 2'b00, word_data(9'd16), 1'b0, NoError);
    bus_read(9'd17, 2'b00, word_data(9'd17), 1'b0, NoError);
    bus_read(9'd31, 2'b00, word_data(9'd31), 1'b0, NoError);
    bus_read(9'd47, 2'b00, word_data(9'd47), 1'b0, NoError);

    // Below and above the window, then locked
    test_name = "refused_read";
    bus_read(9'd15, 2'b11, '0, 1'b1, AccessError);
    bus_read(9'd48, 2'b11, '0, 1'b1, AccessError);
    read_lock_i = 1'b1;
    repeat (2) @(negedge clk_i);
    bus_read(9'd20, 2'b11, '0, 1'b1, AccessError);
    read_lock_i = 1'b0;
    repeat (2) @(negedge clk_i);
    bus_read(9'd21, 2'b00, word_data(9'd21), 1'b0, NoError);

    test_name  = "corr_error";
    inject_err = MacroEccCorrError;
    bus_read(9'd25, 2'b00, word_data(9'd25), 1'b0, MacroEccCorrError);
    inject_err = NoError;
    bus_read(9'd26, 2'b00, word_data(9'd26), 1'b0, NoError);

    test_name  = "fatal_error";
    inject_err = MacroEccUncorrError;
    bus_read(9'd27, 2'b11, '0, 1'b0, MacroEccUncorrError);
    inject_err = NoError;
    exp_fatal  = 1'b1;
    bus_read(9'd28, 2'b11, '0, 1'b1, MacroEccUncorrError);
    bus_read(9'd16, 2'b11, '0, 1'b1, MacroEccUncorrError);
    repeat (4) @(negedge clk_i);

    test_name = "escalation";
    apply_reset();
    run_init();
    escalate_i = 1'b1;
    @(negedge clk_i);
    exp_fatal  = 1'b1;
    // Escalation stays high one more cycle
    @(negedge clk_i);
    escalate_i = 1'b0;
    bus_read(9'd16, 2'b11, '0, 1'b1, FsmStateError);
    bus_read(9'd40, 2'b11, '0, 1'b1, FsmStateError);

    @(negedge clk_i);
    $display("Regression passed");
    $finish;
  end

  // Bound on the whole run
  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Regression failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* filelist.f */
source/otp_part_pkg.sv
source/otp_part_init.sv
source/otp_part_read.sv
source/otp_part_port.sv
source/otp_part_lock.sv
source/otp_part_top.sv
bench/otp_macro_model.sv
bench/otp_part_tb.sv

/* Bender.yml */
package:
  name: otp_part

sources:
  - source/otp_part_pkg.sv
  - source/otp_part_init.sv
  - source/otp_part_read.sv
  - source/otp_part_port.sv
  - source/otp_part_lock.sv
  - source/otp_part_top.sv
  - target: test
    files:
      - bench/otp_macro_model.sv
      - bench/otp_part_tb.sv
